/* list.f */
+incdir+rtl
rtl/rn_pkg.sv
rtl/rn_regfile.sv
rtl/rn_rename_map.sv
rtl/rn_rob_ctrl.sv
rtl/rn_operand_store.sv
rtl/rn_backend_top.sv
sim/tb_clkgen.sv
sim/tb_rn_backend.sv

/* sim/tb_rn_backend.sv */
`default_nettype none

`include "rn_consts.svh"

module tb_rn_backend;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROB_N  = 1 << `RN_ROB_LEN;
    localparam int ARCH_N = 1 << `RN_ARCH_LEN;

    logic                                       clk;
    logic                                       rst_n;
    rn_pkg::dispatch_req_t [`RN_WIDTH-1:0]      disp;
    rn_pkg::arch_rid_t     [`RN_READ_PORTS-1:0] rd_rid;
    rn_pkg::wb_req_t                            wb;
    logic                                       disp_ready;
    rn_pkg::alloc_t        [`RN_WIDTH-1:0]      alloc;
    rn_pkg::read_resp_t    [`RN_READ_PORTS-1:0] rd_resp;
    rn_pkg::retire_t       [`RN_WIDTH-1:0]      retire;

    // Reference model state
    rn_pkg::rename_entry_t m_spec [ARCH_N];
    rn_pkg::rename_entry_t m_comm [ARCH_N];
    rn_pkg::data_t         m_arch [ARCH_N];
    rn_pkg::data_t         m_rdata [ROB_N];
    logic                  m_done [ROB_N];
    rn_pkg::rob_rid_t      m_tail;
    // Occupied ROB entries, oldest first
    rn_pkg::commit_t       m_rob_q [$];
    // Dispatched entries still waiting for writeback
    rn_pkg::rob_rid_t      pend_q [$];

    string  cur_test;
    integer seed;
    logic   aborted;
    int     err_count;
    int     check_count;
    int     test_err_base;
    int     tests_ok;
    int     tests_bad;

    tb_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rn_backend_top u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .dispatch_i       (disp),
        .dispatch_ready_o (disp_ready),
        .alloc_o          (alloc),
        .read_rid_i       (rd_rid),
        .read_o           (rd_resp),
        .wb_i             (wb),
        .commit_o         (retire)
    );

    // Committed when both maps agree, else in flight and ready once its entry is done
    function automatic rn_pkg::read_resp_t ref_read(input rn_pkg::arch_rid_t r);
        rn_pkg::read_resp_t resp;
        resp.rob_id = m_spec[r].rob_id;
        resp.ready  = 1'b1;
        resp.data   = '0;
        if (m_spec[r] == m_comm[r]) begin
            resp.data = m_arch[r];
        end else if (m_done[m_spec[r].rob_id]) begin
            resp.data = m_rdata[m_spec[r].rob_id];
        end else begin
            resp.ready = 1'b0;
        end
        return resp;
    endfunction

    function automatic rn_pkg::alloc_t ref_alloc(input int s);
        rn_pkg::alloc_t a;
        a.rob_id = m_tail + rn_pkg::rob_rid_t'(s);
        a.tier   = ~m_comm[disp[s].arid].tier;
        return a;
    endfunction

    // Head commits when done, the next one only behind it
    function automatic int commits_due();
        if (m_rob_q.size() == 0 || !m_done[m_rob_q[0].rob_id]) return 0;
        if (m_rob_q.size() > 1 && m_done[m_rob_q[1].rob_id]) return 2;
        return 1;
    endfunction

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        rn_pkg::retire_t exp_ret;
        int              n;
        n = commits_due();
        check_val({cur_test, " ready"}, m_rob_q.size() <= ROB_N - 2, disp_ready);
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (disp[s].valid) begin
                check_val($sformatf("%s alloc%0d", cur_test, s), ref_alloc(s), alloc[s]);
            end
            if (s < n) begin
                exp_ret.valid = 1'b1;
                exp_ret.arid  = m_rob_q[s].arid;
                exp_ret.data  = m_rdata[m_rob_q[s].rob_id];
                check_val($sformatf("%s commit%0d", cur_test, s), exp_ret, retire[s]);
            end else begin
                check_val($sformatf("%s commit%0d", cur_test, s), 1'b0, retire[s].valid);
            end
        end
        for (int p = 0; p < `RN_READ_PORTS; p++) begin
            check_val($sformatf("%s read%0d", cur_test, p), ref_read(rd_rid[p]), rd_resp[p]);
        end
    endtask

    // Model state as it will be after the coming rising edge
    task automatic advance_model();
        rn_pkg::alloc_t  a [`RN_WIDTH];
        rn_pkg::commit_t ent;
        logic            rdy;
        int              n;
        rdy = (m_rob_q.size() <= ROB_N - 2);
        n   = commits_due();
        // Tiers come from the committed map before this edge
        for (int s = 0; s < `RN_WIDTH; s++) begin
            a[s] = ref_alloc(s);
        end
        repeat (n) begin
            ent = m_rob_q.pop_front();
            m_comm[ent.arid].tier   = ent.tier;
            m_comm[ent.arid].rob_id = ent.rob_id;
            m_arch[ent.arid]        = m_rdata[ent.rob_id];
            m_done[ent.rob_id]      = 1'b0;
        end
        if (wb.valid) begin
            m_done[wb.rob_id]  = 1'b1;
            m_rdata[wb.rob_id] = wb.data;
        end
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (rdy && disp[s].valid) begin
                m_spec[disp[s].arid].tier   = a[s].tier;
                m_spec[disp[s].arid].rob_id = a[s].rob_id;
                m_rob_q.push_back({1'b1, disp[s].arid, a[s].rob_id, a[s].tier});
                pend_q.push_back(a[s].rob_id);
                m_tail = m_tail + 1'b1;
            end
        end
    endtask

    // Inputs settle 1 ns after the rising edge, so the falling edge sees them stable
    always @(negedge clk) begin
        if (rst_n) begin
            check_outputs();
            advance_model();
        end
    end

    // Every cycle starts with no dispatch and no writeback
    task automatic next_cycle();
        @(posedge clk);
        #1;
        disp = '0;
        wb   = '0;
    endtask

    task automatic offer(input logic v0, input int a0, input logic v1, input int a1);
        disp[0].valid = v0;
        disp[0].arid  = rn_pkg::arch_rid_t'(a0);
        disp[1].valid = v1;
        disp[1].arid  = rn_pkg::arch_rid_t'(a1);
    endtask

    task automatic set_reads(input int r0, input int r1, input int r2, input int r3);
        rd_rid[0] = rn_pkg::arch_rid_t'(r0);
        rd_rid[1] = rn_pkg::arch_rid_t'(r1);
        rd_rid[2] = rn_pkg::arch_rid_t'(r2);
        rd_rid[3] = rn_pkg::arch_rid_t'(r3);
    endtask

    task automatic write_back(input int idx);
        wb.valid  = 1'b1;
        wb.rob_id = pend_q[idx];
        wb.data   = $random(seed);
        pend_q.delete(idx);
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (!rst_n && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("timeout: reset was never released");
            err_count++;
            aborted = 1'b1;
        end
    endtask

    // Write back the oldest pending entry each cycle until the ROB is empty
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        next_cycle();
        while (m_rob_q.size() != 0 && cycles < 100) begin
            if (pend_q.size() != 0) write_back(0);
            next_cycle();
            cycles++;
        end
        if (m_rob_q.size() != 0) begin
            $display("timeout: ROB did not drain during test %s", cur_test);
            err_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic test_begin(input string name);
        cur_test      = name;
        test_err_base = err_count;
    endtask

    task automatic test_end();
        next_cycle();
        if (err_count == test_err_base) begin
            tests_ok++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", cur_test, err_count - test_err_base);
        end
    endtask

    task automatic run_reset();
        test_begin("reset");
        for (int i = 0; i < ARCH_N / 4; i++) begin
            next_cycle();
            set_reads(4 * i, 4 * i + 1, 4 * i + 2, 4 * i + 3);
        end
        test_end();
    endtask

    // Two dispatched per cycle against one writeback, so ids wrap and the ROB fills
    task automatic run_alloc();
        test_begin("alloc");
        for (int i = 0; i < 24; i++) begin
            next_cycle();
            set_reads(i, i + 7, 2 * i, 31 - i);
            if (m_rob_q.size() <= ROB_N - 2) offer(1'b1, 3 * i, 1'b1, 3 * i + 1);
            if (pend_q.size() != 0) write_back(0);
        end
        wait_drain();
        test_end();
    endtask

    task automatic run_inflight();
        test_begin("inflight");
        next_cycle();
        set_reads(5, 9, 5, 0);
        offer(1'b1, 5, 1'b1, 9);
        repeat (3) next_cycle();
        write_back(0);
        repeat (2) next_cycle();
        write_back(0);
        repeat (2) next_cycle();
        wait_drain();
        test_end();
    endtask

    // Youngest written back first
    task automatic run_order();
        test_begin("order");
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            offer(1'b1, 2 * i + 1, 1'b1, 2 * i + 2);
        end
        set_reads(1, 2, 3, 6);
        for (int i = 0; i < 6; i++) begin
            next_cycle();
            write_back(pend_q.size() - 1);
        end
        wait_drain();
        test_end();
    endtask

    // Eight pairs fill all 16 entries, the last four pairs are refused
    task automatic run_backpressure();
        test_begin("backpressure");
        set_reads(10, 11, 12, 13);
        for (int i = 0; i < 12; i++) begin
            next_cycle();
            offer(1'b1, 10 + i, 1'b1, 20 + i);
        end
        while (pend_q.size() != 0) begin
            next_cycle();
            write_back($unsigned($random(seed)) % pend_q.size());
        end
        wait_drain();
        repeat (2) next_cycle();
        test_end();
    endtask

    task automatic run_random();
        logic [31:0] r;
        test_begin("random");
        for (int i = 0; i < 400; i++) begin
            next_cycle();
            r = $random(seed);
            offer(r[0] | r[1], r[6:2], (r[0] | r[1]) & r[7], r[12:8]);
            if (pend_q.size() != 0 && (r[13] | r[14])) begin
                write_back($unsigned($random(seed)) % pend_q.size());
            end
            r = $random(seed);
            set_reads(r[4:0], r[9:5], r[14:10], r[19:15]);
        end
        wait_drain();
        test_end();
    endtask

    initial begin
        seed        = 85;
        aborted     = 1'b0;
        err_count   = 0;
        check_count = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        cur_test    = "reset";
        disp        = '0;
        wb          = '0;
        rd_rid      = '0;
        m_tail      = '0;
        for (int i = 0; i < ARCH_N; i++) begin
            m_spec[i] = '0;
            m_comm[i] = '0;
            m_arch[i] = '0;
        end
        for (int i = 0; i < ROB_N; i++) begin
            m_done[i]  = 1'b0;
            m_rdata[i] = '0;
        end
        wait_reset();
        if (!aborted) run_reset();
        if (!aborted) run_alloc();
        if (!aborted) run_inflight();
        if (!aborted) run_order();
        if (!aborted) run_backpressure();
        if (!aborted) run_random();
        $display("tests ok %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_ok, tests_bad, check_count, err_count);
        if (err_count == 0 && !aborted) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_clkgen.sv */
`default_nettype none

// Free running clock and power-on reset for the testbench
module tb_clkgen #(
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Released a little after the edge, like the other inputs
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/rn_backend_top.sv */
`default_nettype none

`include "rn_consts.svh"

module rn_backend_top (
    input  wire logic                                     clk,
    input  wire logic                                     rst_n,
    input  wire rn_pkg::dispatch_req_t [`RN_WIDTH-1:0]    dispatch_i,
    output logic                                          dispatch_ready_o,
    output rn_pkg::alloc_t             [`RN_WIDTH-1:0]    alloc_o,
    input  wire rn_pkg::arch_rid_t     [`RN_READ_PORTS-1:0] read_rid_i,
    output rn_pkg::read_resp_t         [`RN_READ_PORTS-1:0] read_o,
    input  wire rn_pkg::wb_req_t                          wb_i,
    output rn_pkg::retire_t            [`RN_WIDTH-1:0]    commit_o
);

    rn_pkg::rob_rid_t [`RN_READ_PORTS-1:0]   map_rid;
    logic             [`RN_READ_PORTS-1:0]   map_match;
    logic             [(1<<`RN_ROB_LEN)-1:0] rob_done;
    rn_pkg::commit_t  [`RN_WIDTH-1:0]        rob_commit;

    rn_rename_map u_rename_map (
        .clk              (clk),
        .rst_n            (rst_n),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_i (dispatch_ready_o),
        .read_rid_i       (read_rid_i),
        .commit_i         (rob_commit),
        .alloc_o          (alloc_o),
        .map_rid_o        (map_rid),
        .map_match_o      (map_match)
    );

    rn_rob_ctrl u_rob_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .dispatch_i       (dispatch_i),
        .alloc_i          (alloc_o),
        .wb_i             (wb_i),
        .dispatch_ready_o (dispatch_ready_o),
        .done_o           (rob_done),
        .commit_o         (rob_commit)
    );

    rn_operand_store u_operand_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .read_rid_i  (read_rid_i),
        .map_rid_i   (map_rid),
        .map_match_i (map_match),
        .done_i      (rob_done),
        .wb_i        (wb_i),
        .commit_i    (rob_commit),
        .read_o      (read_o),
        .retire_o    (commit_o)
    );

endmodule

`default_nettype wire

/* rtl/rn_operand_store.sv */
`default_nettype none

`include "rn_consts.svh"

// ROB data, architectural file and operand selection
module rn_operand_store (
    input  wire logic                                        clk,
    input  wire logic                                        rst_n,
    input  wire rn_pkg::arch_rid_t  [`RN_READ_PORTS-1:0]     read_rid_i,
    input  wire rn_pkg::rob_rid_t   [`RN_READ_PORTS-1:0]     map_rid_i,
    input  wire logic               [`RN_READ_PORTS-1:0]     map_match_i,
    input  wire logic               [(1<<`RN_ROB_LEN)-1:0]   done_i,
    input  wire rn_pkg::wb_req_t                             wb_i,
    input  wire rn_pkg::commit_t    [`RN_WIDTH-1:0]          commit_i,
    output rn_pkg::read_resp_t      [`RN_READ_PORTS-1:0]     read_o,
    output rn_pkg::retire_t         [`RN_WIDTH-1:0]          retire_o
);

    localparam int ROB_R = `RN_READ_PORTS + `RN_WIDTH;

    rn_pkg::rob_rid_t  [ROB_R-1:0]          rob_raddr;
    rn_pkg::data_t     [ROB_R-1:0]          rob_rd;
    rn_pkg::data_t     [`RN_READ_PORTS-1:0] arch_rd;

    logic              [`RN_WIDTH-1:0]      arch_we;
    rn_pkg::arch_rid_t [`RN_WIDTH-1:0]      arch_waddr;
    rn_pkg::data_t     [`RN_WIDTH-1:0]      arch_wdata;

    // Operand ports read by speculative id, commit ports by head ids
    for (genvar p = 0; p < `RN_READ_PORTS; p++) begin : g_read
        assign rob_raddr[p] = map_rid_i[p];

        always_comb begin
            read_o[p].rob_id = map_rid_i[p];
            if (map_match_i[p]) begin
                read_o[p].ready = 1'b1;
                read_o[p].data  = arch_rd[p];
            end else if (done_i[map_rid_i[p]]) begin
                read_o[p].ready = 1'b1;
                read_o[p].data  = rob_rd[p];
            end else begin
                read_o[p].ready = 1'b0;
                read_o[p].data  = '0;
            end
        end
    end

    for (genvar s = 0; s < `RN_WIDTH; s++) begin : g_commit
        assign rob_raddr[`RN_READ_PORTS + s] = commit_i[s].rob_id;
        assign arch_we[s]        = commit_i[s].valid;
        assign arch_waddr[s]     = commit_i[s].arid;
        assign arch_wdata[s]     = rob_rd[`RN_READ_PORTS + s];
        assign retire_o[s].valid = commit_i[s].valid;
        assign retire_o[s].arid  = commit_i[s].arid;
        assign retire_o[s].data  = arch_wdata[s];
    end

    rn_regfile #(
        .entry_t (rn_pkg::data_t),
        .DEPTH   (1 << `RN_ROB_LEN),
        .R_PORTS (ROB_R),
        .W_PORTS (1)
    ) u_rob_data (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (rob_raddr),
        .rdata_o (rob_rd),
        .we_i    (wb_i.valid),
        .waddr_i (wb_i.rob_id),
        .wdata_i (wb_i.data)
    );

    rn_regfile #(
        .entry_t (rn_pkg::data_t),
        .DEPTH   (1 << `RN_ARCH_LEN),
        .R_PORTS (`RN_READ_PORTS),
        .W_PORTS (`RN_WIDTH)
    ) u_arch_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (read_rid_i),
        .rdata_o (arch_rd),
        .we_i    (arch_we),
        .waddr_i (arch_waddr),
        .wdata_i (arch_wdata)
    );

endmodule

`default_nettype wire

/* rtl/rn_rob_ctrl.sv */
`default_nettype none

`include "rn_consts.svh"

// ROB head, occupancy, done tracking and in-order commit selection
module rn_rob_ctrl (
    input  wire logic                                          clk,
    input  wire logic                                          rst_n,
    input  wire rn_pkg::dispatch_req_t [`RN_WIDTH-1:0]         dispatch_i,
    input  wire rn_pkg::alloc_t        [`RN_WIDTH-1:0]         alloc_i,
    input  wire rn_pkg::wb_req_t                               wb_i,
    output logic                                               dispatch_ready_o,
    output logic                       [(1<<`RN_ROB_LEN)-1:0]  done_o,
    output rn_pkg::commit_t            [`RN_WIDTH-1:0]         commit_o
);

    localparam int DEPTH = 1 << `RN_ROB_LEN;
    localparam int CNT_W = `RN_ROB_LEN + 1;

    rn_pkg::rob_rid_t head_q;
    logic [CNT_W-1:0] count_q;
    logic [DEPTH-1:0] done_q;

    // Per-entry destination and tier, written at allocation
    rn_pkg::arch_rid_t [DEPTH-1:0] dest_q;
    logic              [DEPTH-1:0] tier_q;

    logic             [`RN_WIDTH-1:0] accept;
    logic             [`RN_WIDTH-1:0] retire;
    rn_pkg::rob_rid_t [`RN_WIDTH-1:0] slot_rid;
    logic [1:0]                       n_accept;
    logic [1:0]                       n_retire;

    // Room for a full two-wide dispatch
    assign dispatch_ready_o = (count_q <= CNT_W'(DEPTH - `RN_WIDTH));

    for (genvar s = 0; s < `RN_WIDTH; s++) begin : g_accept
        assign accept[s] = dispatch_i[s].valid & dispatch_ready_o;
    end

    assign n_accept = 2'(accept[0]) + 2'(accept[1]);

    // Head and the entry behind it, oldest first
    assign slot_rid[0] = head_q;
    assign slot_rid[1] = head_q + 1'b1;

    // Second slot only commits behind the first
    assign retire[0] = (count_q != '0) && done_q[slot_rid[0]];
    assign retire[1] = retire[0] && (count_q > CNT_W'(1)) && done_q[slot_rid[1]];

    assign n_retire = 2'(retire[0]) + 2'(retire[1]);

    for (genvar s = 0; s < `RN_WIDTH; s++) begin : g_commit
        assign commit_o[s].valid  = retire[s];
        assign commit_o[s].arid   = dest_q[slot_rid[s]];
        assign commit_o[s].rob_id = slot_rid[s];
        assign commit_o[s].tier   = tier_q[slot_rid[s]];
    end

    assign done_o = done_q;

    always_ff @(posedge clk) begin
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (accept[s]) begin
                dest_q[alloc_i[s].rob_id] <= dispatch_i[s].arid;
                tier_q[alloc_i[s].rob_id] <= alloc_i[s].tier;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            head_q  <= head_q + rn_pkg::rob_rid_t'(n_retire);
            count_q <= count_q + CNT_W'(n_accept) - CNT_W'(n_retire);
            for (int s = 0; s < `RN_WIDTH; s++) begin
                if (retire[s]) begin
                    done_q[slot_rid[s]] <= 1'b0;
                end
            end
            // Writeback never targets an entry that is committing
            if (wb_i.valid) begin
                done_q[wb_i.rob_id] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/rn_rename_map.sv */
`default_nettype none

`include "rn_consts.svh"

// Speculative and committed rename tables with ROB id allocation
module rn_rename_map (
    input  wire logic                                         clk,
    input  wire logic                                         rst_n,
    input  wire rn_pkg::dispatch_req_t [`RN_WIDTH-1:0]        dispatch_i,
    input  wire logic                                         dispatch_ready_i,
    input  wire rn_pkg::arch_rid_t     [`RN_READ_PORTS-1:0]   read_rid_i,
    input  wire rn_pkg::commit_t       [`RN_WIDTH-1:0]        commit_i,
    output rn_pkg::alloc_t             [`RN_WIDTH-1:0]        alloc_o,
    output rn_pkg::rob_rid_t           [`RN_READ_PORTS-1:0]   map_rid_o,
    output logic                       [`RN_READ_PORTS-1:0]   map_match_o
);

    localparam int MAP_DEPTH = 1 << `RN_ARCH_LEN;
    localparam int C_PORTS   = `RN_READ_PORTS + `RN_WIDTH;

    rn_pkg::rob_rid_t tail_q;
    logic [1:0]       n_accept;

    logic                  [`RN_WIDTH-1:0]      accept;
    rn_pkg::arch_rid_t     [`RN_WIDTH-1:0]      disp_arid;
    rn_pkg::rename_entry_t [`RN_WIDTH-1:0]      spec_wdata;
    rn_pkg::rename_entry_t [`RN_READ_PORTS-1:0] spec_rd;

    logic                  [`RN_WIDTH-1:0]      commit_we;
    rn_pkg::arch_rid_t     [`RN_WIDTH-1:0]      commit_arid;
    rn_pkg::rename_entry_t [`RN_WIDTH-1:0]      comm_wdata;
    rn_pkg::arch_rid_t     [C_PORTS-1:0]        comm_raddr;
    rn_pkg::rename_entry_t [C_PORTS-1:0]        comm_rd;

    // Allocation: consecutive ROB ids from the tail, tier flipped from committed map
    for (genvar s = 0; s < `RN_WIDTH; s++) begin : g_alloc
        assign accept[s]            = dispatch_i[s].valid & dispatch_ready_i;
        assign disp_arid[s]         = dispatch_i[s].arid;
        assign alloc_o[s].rob_id    = tail_q + rn_pkg::rob_rid_t'(s);
        assign alloc_o[s].tier      = ~comm_rd[`RN_READ_PORTS + s].tier;
        assign spec_wdata[s].rob_id = alloc_o[s].rob_id;
        assign spec_wdata[s].tier   = alloc_o[s].tier;
    end

    assign n_accept = 2'(accept[0]) + 2'(accept[1]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail_q <= '0;
        end else begin
            tail_q <= tail_q + rn_pkg::rob_rid_t'(n_accept);
        end
    end

    // Commit writes into the committed table
    for (genvar s = 0; s < `RN_WIDTH; s++) begin : g_commit
        assign commit_we[s]         = commit_i[s].valid;
        assign commit_arid[s]       = commit_i[s].arid;
        assign comm_wdata[s].tier   = commit_i[s].tier;
        assign comm_wdata[s].rob_id = commit_i[s].rob_id;
    end

    // Committed table reads sources first, then the dispatch destinations
    for (genvar p = 0; p < `RN_READ_PORTS; p++) begin : g_src
        assign comm_raddr[p] = read_rid_i[p];
        assign map_rid_o[p]   = spec_rd[p].rob_id;
        assign map_match_o[p] = (spec_rd[p] == comm_rd[p]);
    end

    for (genvar s = 0; s < `RN_WIDTH; s++) begin : g_dst
        assign comm_raddr[`RN_READ_PORTS + s] = disp_arid[s];
    end

    rn_regfile #(
        .entry_t (rn_pkg::rename_entry_t),
        .DEPTH   (MAP_DEPTH),
        .R_PORTS (`RN_READ_PORTS),
        .W_PORTS (`RN_WIDTH)
    ) u_spec_map (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (read_rid_i),
        .rdata_o (spec_rd),
        .we_i    (accept),
        .waddr_i (disp_arid),
        .wdata_i (spec_wdata)
    );

    rn_regfile #(
        .entry_t (rn_pkg::rename_entry_t),
        .DEPTH   (MAP_DEPTH),
        .R_PORTS (C_PORTS),
        .W_PORTS (`RN_WIDTH)
    ) u_comm_map (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_i (comm_raddr),
        .rdata_o (comm_rd),
        .we_i    (commit_we),
        .waddr_i (commit_arid),
        .wdata_i (comm_wdata)
    );

endmodule

`default_nettype wire

/* rtl/rn_regfile.sv */
`default_nettype none

// Flop based register file with combinational read ports
module rn_regfile #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 16,
    parameter int  R_PORTS = 2,
    parameter int  W_PORTS = 1
) (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,
    input  wire logic   [R_PORTS-1:0][$clog2(DEPTH)-1:0] raddr_i,
    output entry_t      [R_PORTS-1:0]                    rdata_o,
    input  wire logic   [W_PORTS-1:0]                    we_i,
    input  wire logic   [W_PORTS-1:0][$clog2(DEPTH)-1:0] waddr_i,
    input  wire entry_t [W_PORTS-1:0]                    wdata_i
);

    entry_t [DEPTH-1:0] mem_q;

    // Ports are applied in order, so the highest write port wins a collision
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_q <= '0;
        end else begin
            for (int w = 0; w < W_PORTS; w++) begin
                if (we_i[w]) begin
                    mem_q[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    for (genvar r = 0; r < R_PORTS; r++) begin : g_read
        assign rdata_o[r] = mem_q[raddr_i[r]];
    end

endmodule

`default_nettype wire

/* rtl/rn_pkg.sv */
`default_nettype none

`include "rn_consts.svh"

package rn_pkg;

    typedef logic [`RN_ARCH_LEN-1:0] arch_rid_t;
    typedef logic [`RN_ROB_LEN-1:0]  rob_rid_t;
    typedef logic [`RN_DATA_W-1:0]   data_t;

    // Map table entry, tier in the top bit
    typedef struct packed {
        logic     tier;
        rob_rid_t rob_id;
    } rename_entry_t;

    typedef struct packed {
        logic      valid;
        arch_rid_t arid;
    } dispatch_req_t;

    typedef struct packed {
        rob_rid_t rob_id;
        logic     tier;
    } alloc_t;

    typedef struct packed {
        logic     ready;
        rob_rid_t rob_id;
        data_t    data;
    } read_resp_t;

    typedef struct packed {
        logic     valid;
        rob_rid_t rob_id;
        data_t    data;
    } wb_req_t;

    // Internal commit slot, from ROB control to map and operand store
    typedef struct packed {
        logic      valid;
        arch_rid_t arid;
        rob_rid_t  rob_id;
        logic      tier;
    } commit_t;

    // Commit report at the top level
    typedef struct packed {
        logic      valid;
        arch_rid_t arid;
        data_t     data;
    } retire_t;

endpackage

`default_nettype wire

/* rtl/rn_consts.svh */
`ifndef RN_CONSTS_SVH
`define RN_CONSTS_SVH

// ROB id width, 16 entries
`define RN_ROB_LEN 4

// Architectural register id width, 32 registers
`define RN_ARCH_LEN 5

// Data word width
`define RN_DATA_W 32

// Operand read ports
`define RN_READ_PORTS 4

// Dispatch and commit width
`define RN_WIDTH 2

`endif
